//--- source/snn_consts.svh
`ifndef SNN_CONSTS_SVH
`define SNN_CONSTS_SVH

// ----------------------------------------
// network size
// ----------------------------------------
`define SNN_N_PRE       16   // pre-synaptic inputs, one synapse row each
`define SNN_N_POST      8    // neurons updated in parallel
`define SNN_TIME_STEPS  4    // markers per sample

// ----------------------------------------
// datapath widths
// ----------------------------------------
`define SNN_W_WIDTH     8    // signed weight
`define SNN_MEM_WIDTH   12   // signed membrane, saturating
`define SNN_CNT_WIDTH   3    // spike count per neuron
`define SNN_GOOD_WIDTH  16   // sum of squared counts

// firing level, compared with >=
`define SNN_THRESHOLD   64

// ----------------------------------------
// AER word layout
// ----------------------------------------
// bit 7 set -> time-step marker
// bits 3:0  -> pre index, bits 6:4 unused
`define SNN_AER_WIDTH   8

`endif

//--- source/snn_pkg.sv
`include "snn_consts.svh"

package snn_pkg;

    // one synapse, signed
    typedef logic signed [`SNN_W_WIDTH-1:0] weight_t;

    // one row = one weight per neuron, neuron 0 in the low byte
    typedef weight_t [`SNN_N_POST-1:0] syn_row_t;

    typedef logic signed [`SNN_MEM_WIDTH-1:0] membrane_t;
    typedef logic [`SNN_CNT_WIDTH-1:0]        spike_cnt_t;
    typedef logic [`SNN_GOOD_WIDTH-1:0]       goodness_t;

    typedef logic [$clog2(`SNN_N_PRE)-1:0]    pre_idx_t;   // synapse row select
    typedef logic [$clog2(`SNN_N_POST)-1:0]   post_idx_t;  // neuron index
    typedef logic [`SNN_AER_WIDTH-1:0]        aer_addr_t;

    // controller FSM
    typedef enum logic [2:0] {
        st_idle,
        st_read,          // synapse row fetch
        st_integrate,     // add row into membranes
        st_fire,          // threshold compare
        st_drain,         // output spikes in flight
        st_goodness,      // end of sample sum
        st_wait_release   // ack held until req drops
    } ctrl_state_t;

endpackage

//--- source/tstep_counter.sv
`timescale 1ns/1ps
`include "snn_consts.svh"

module tstep_counter (
    input  logic CLK,
    input  logic rst,
    input  logic step_adv,   // one pulse per finished marker
    output logic last_step   // current step closes the sample
);

    localparam int CW = $clog2(`SNN_TIME_STEPS);

    logic [CW-1:0] step_cnt;

    assign last_step = (step_cnt == CW'(`SNN_TIME_STEPS - 1));

    always_ff @(posedge CLK) begin
        if (rst) begin
            step_cnt <= '0;
        end else if (step_adv) begin
            if (last_step) begin
                step_cnt <= '0;                // new sample
            end else begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

endmodule

//--- source/synapse_mem.sv
`timescale 1ns/1ps
`include "snn_consts.svh"

module synapse_mem (
    input  logic               CLK,
    // program port, between samples only
    input  logic               prog_we,
    input  snn_pkg::pre_idx_t  prog_addr,
    input  snn_pkg::syn_row_t  prog_data,
    // event read
    input  logic               syn_rd_en,
    input  snn_pkg::pre_idx_t  syn_rd_addr,
    output snn_pkg::syn_row_t  syn_row
);

    // one row per pre-synaptic input
    snn_pkg::syn_row_t rows [`SNN_N_PRE];

    // ----------------------------------------
    // write side
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (prog_we) begin
            rows[prog_addr] <= prog_data;   // visible to reads next cycle
        end
    end

    // ----------------------------------------
    // read side, registered
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (syn_rd_en) begin
            syn_row <= rows[syn_rd_addr];   // held until the next read
        end
    end

endmodule

//--- source/neuron_array.sv
`timescale 1ns/1ps
`include "snn_consts.svh"

module neuron_array (
    input  logic                                     CLK,
    input  logic                                     rst,
    input  snn_pkg::syn_row_t                        syn_row,
    input  logic                                     integ_en,
    input  logic                                     fire_en,
    input  logic                                     sample_clear,
    output logic [`SNN_N_POST-1:0]                   fired,
    output snn_pkg::spike_cnt_t [`SNN_N_POST-1:0]    spike_counts
);

    localparam int MW = `SNN_MEM_WIDTH;
    localparam snn_pkg::membrane_t MEM_MAX = {1'b0, {(MW-1){1'b1}}};
    localparam snn_pkg::membrane_t MEM_MIN = {1'b1, {(MW-1){1'b0}}};
    localparam snn_pkg::membrane_t THRESH  = MW'(`SNN_THRESHOLD);
    localparam snn_pkg::spike_cnt_t CNT_MAX = '1;

    snn_pkg::membrane_t      membrane [`SNN_N_POST];
    snn_pkg::membrane_t      sat_sum  [`SNN_N_POST];
    logic signed [MW:0]      sum_ext  [`SNN_N_POST];   // one guard bit

    // ----------------------------------------
    // saturating add, all neurons at once
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < `SNN_N_POST; i++) begin
            sum_ext[i] = $signed(membrane[i]) + $signed(syn_row[i]);  // both sign-extend
            if (sum_ext[i][MW] != sum_ext[i][MW-1]) begin
                sat_sum[i] = sum_ext[i][MW] ? MEM_MIN : MEM_MAX;      // overflow, clamp
            end else begin
                sat_sum[i] = sum_ext[i][MW-1:0];
            end
        end
    end

    // ----------------------------------------
    // membrane, fire and count state
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (rst || sample_clear) begin
            for (int i = 0; i < `SNN_N_POST; i++) begin
                membrane[i]     <= '0;
                spike_counts[i] <= '0;
            end
            fired <= '0;
        end else if (integ_en) begin
            for (int i = 0; i < `SNN_N_POST; i++) begin
                membrane[i] <= sat_sum[i];
            end
        end else if (fire_en) begin
            for (int i = 0; i < `SNN_N_POST; i++) begin
                fired[i] <= (membrane[i] >= THRESH);   // signed, negatives never fire
                if (membrane[i] >= THRESH) begin
                    membrane[i] <= '0;                 // reset on fire, no leak otherwise
                    if (spike_counts[i] != CNT_MAX) begin
                        spike_counts[i] <= spike_counts[i] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- source/spike_aer_out.sv
`timescale 1ns/1ps
`include "snn_consts.svh"

module spike_aer_out (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    out_start,   // fired vector valid
    input  logic [`SNN_N_POST-1:0]  fired,
    output logic                    out_busy,
    output snn_pkg::aer_addr_t      aerout_addr,
    output logic                    aerout_req,
    input  logic                    aerout_ack
);

    logic [`SNN_N_POST-1:0] pending;    // spikes still to send
    logic                   wait_low;   // req dropped, ack not yet
    logic                   launch;
    snn_pkg::post_idx_t     next_idx;

    // lowest set bit first -> ascending order
    always_comb begin
        next_idx = '0;
        for (int i = `SNN_N_POST - 1; i >= 0; i--) begin
            if (pending[i]) begin
                next_idx = snn_pkg::post_idx_t'(i);
            end
        end
    end

    assign launch = !out_start && !aerout_req && !wait_low && (|pending);

    // ----------------------------------------
    // four-phase sender
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            pending    <= '0;
            aerout_req <= 1'b0;
            wait_low   <= 1'b0;
            out_busy   <= 1'b0;
        end else if (out_start) begin
            pending  <= fired;
            out_busy <= 1'b1;                  // drops next cycle if empty
        end else if (aerout_req) begin
            if (aerout_ack) begin
                aerout_req <= 1'b0;
                wait_low   <= 1'b1;
            end
        end else if (wait_low) begin
            if (!aerout_ack) begin
                wait_low <= 1'b0;              // receiver released
            end
        end else if (launch) begin
            aerout_req        <= 1'b1;
            pending[next_idx] <= 1'b0;
        end else begin
            out_busy <= 1'b0;                  // nothing left this step
        end
    end

    // address only moves at launch
    always_ff @(posedge CLK) begin
        if (launch) begin
            aerout_addr <= snn_pkg::aer_addr_t'(next_idx);
        end
    end

endmodule

//--- source/goodness_acc.sv
`timescale 1ns/1ps
`include "snn_consts.svh"

module goodness_acc (
    input  logic                                     CLK,
    input  logic                                     rst,
    input  logic                                     good_start,
    input  snn_pkg::spike_cnt_t [`SNN_N_POST-1:0]    spike_counts,
    output logic                                     good_done,
    output snn_pkg::goodness_t                       goodness
);

    logic                          active;
    snn_pkg::post_idx_t            idx;      // neuron being squared
    snn_pkg::goodness_t            acc;
    logic [2*`SNN_CNT_WIDTH-1:0]   sq;

    assign sq = spike_counts[idx] * spike_counts[idx];

    // ----------------------------------------
    // one neuron per cycle
    // ----------------------------------------
    always_ff @(posedge CLK) begin
        if (rst) begin
            active    <= 1'b0;
            good_done <= 1'b0;
            goodness  <= '0;
        end else begin
            good_done <= 1'b0;
            if (good_start) begin
                active <= 1'b1;
                idx    <= '0;
                acc    <= '0;
            end else if (active) begin
                acc <= acc + snn_pkg::goodness_t'(sq);
                idx <= idx + 1'b1;
                if (idx == snn_pkg::post_idx_t'(`SNN_N_POST - 1)) begin
                    active    <= 1'b0;
                    goodness  <= acc + snn_pkg::goodness_t'(sq);  // held till next sample
                    good_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- source/snn_controller.sv
`timescale 1ns/1ps
`include "snn_consts.svh"

module snn_controller (
    input  logic                CLK,
    input  logic                rst,
    // input AER link
    input  snn_pkg::aer_addr_t  aerin_addr,
    input  logic                aerin_req,
    output logic                aerin_ack,
    // synapse read
    output logic                syn_rd_en,
    output snn_pkg::pre_idx_t   syn_rd_addr,
    // neuron strobes
    output logic                integ_en,
    output logic                fire_en,
    // time step
    output logic                step_adv,
    input  logic                last_step,
    // output spikes
    output logic                out_start,
    input  logic                out_busy,
    // goodness
    output logic                good_start,
    input  logic                good_done,
    output logic                sample_clear,
    output logic                sample_done
);

    localparam int PW = $clog2(`SNN_N_PRE);

    snn_pkg::ctrl_state_t state;
    logic                 is_marker;
    logic                 drain_done;

    assign is_marker   = aerin_addr[`SNN_AER_WIDTH-1];
    assign syn_rd_addr = aerin_addr[PW-1:0];       // addr stable while req high

    // ----------------------------------------
    // state decoded strobes
    // ----------------------------------------
    assign syn_rd_en    = (state == snn_pkg::st_read);
    assign integ_en     = (state == snn_pkg::st_integrate);
    assign fire_en      = (state == snn_pkg::st_fire);
    assign aerin_ack    = (state == snn_pkg::st_wait_release);
    assign sample_done  = (state == snn_pkg::st_goodness) && good_done;
    assign sample_clear = sample_done;             // clear right after goodness latched

    // out_start still high means the sender has not latched yet
    assign drain_done = !out_start && !out_busy;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= snn_pkg::st_idle;
            out_start  <= 1'b0;
            step_adv   <= 1'b0;
            good_start <= 1'b0;
        end else begin
            out_start  <= 1'b0;   // single-cycle pulses
            step_adv   <= 1'b0;
            good_start <= 1'b0;
            case (state)
                snn_pkg::st_idle: begin
                    if (aerin_req) begin
                        state <= is_marker ? snn_pkg::st_fire : snn_pkg::st_read;
                    end
                end
                snn_pkg::st_read: begin
                    state <= snn_pkg::st_integrate;   // row arrives now
                end
                snn_pkg::st_integrate: begin
                    state <= snn_pkg::st_wait_release;
                end
                snn_pkg::st_fire: begin
                    out_start <= 1'b1;                // fired vector ready next cycle
                    state     <= snn_pkg::st_drain;
                end
                snn_pkg::st_drain: begin
                    if (drain_done) begin
                        step_adv <= 1'b1;
                        if (last_step) begin
                            good_start <= 1'b1;
                            state      <= snn_pkg::st_goodness;
                        end else begin
                            state <= snn_pkg::st_wait_release;
                        end
                    end
                end
                snn_pkg::st_goodness: begin
                    if (good_done) begin
                        state <= snn_pkg::st_wait_release;
                    end
                end
                snn_pkg::st_wait_release: begin
                    if (!aerin_req) begin
                        state <= snn_pkg::st_idle;    // ack low next cycle
                    end
                end
                default: begin
                    state <= snn_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

//--- source/snn_core.sv
`timescale 1ns/1ps
`include "snn_consts.svh"

module snn_core (
    input  logic                CLK,
    input  logic                rst,
    // input AER link
    input  snn_pkg::aer_addr_t  aerin_addr,
    input  logic                aerin_req,
    output logic                aerin_ack,
    // output AER link
    output snn_pkg::aer_addr_t  aerout_addr,
    output logic                aerout_req,
    input  logic                aerout_ack,
    // weight program port
    input  logic                prog_we,
    input  snn_pkg::pre_idx_t   prog_addr,
    input  snn_pkg::syn_row_t   prog_data,
    // per-sample result
    output logic                sample_done,
    output snn_pkg::goodness_t  goodness
);

    // ----------------------------------------
    // internal wires
    // ----------------------------------------
    logic                                   syn_rd_en;
    snn_pkg::pre_idx_t                      syn_rd_addr;
    snn_pkg::syn_row_t                      syn_row;
    logic                                   integ_en;
    logic                                   fire_en;
    logic                                   step_adv;
    logic                                   last_step;
    logic                                   out_start;
    logic                                   out_busy;
    logic                                   good_start;
    logic                                   good_done;
    logic                                   sample_clear;
    logic [`SNN_N_POST-1:0]                 fired;
    snn_pkg::spike_cnt_t [`SNN_N_POST-1:0]  spike_counts;

    snn_controller u_ctrl (
        .CLK          (CLK),
        .rst          (rst),
        .aerin_addr   (aerin_addr),
        .aerin_req    (aerin_req),
        .aerin_ack    (aerin_ack),
        .syn_rd_en    (syn_rd_en),
        .syn_rd_addr  (syn_rd_addr),
        .integ_en     (integ_en),
        .fire_en      (fire_en),
        .step_adv     (step_adv),
        .last_step    (last_step),
        .out_start    (out_start),
        .out_busy     (out_busy),
        .good_start   (good_start),
        .good_done    (good_done),
        .sample_clear (sample_clear),
        .sample_done  (sample_done)
    );

    tstep_counter u_tstep (
        .CLK       (CLK),
        .rst       (rst),
        .step_adv  (step_adv),
        .last_step (last_step)
    );

    synapse_mem u_syn (
        .CLK         (CLK),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .syn_rd_en   (syn_rd_en),
        .syn_rd_addr (syn_rd_addr),
        .syn_row     (syn_row)
    );

    neuron_array u_neur (
        .CLK          (CLK),
        .rst          (rst),
        .syn_row      (syn_row),
        .integ_en     (integ_en),
        .fire_en      (fire_en),
        .sample_clear (sample_clear),
        .fired        (fired),
        .spike_counts (spike_counts)
    );

    spike_aer_out u_aerout (
        .CLK         (CLK),
        .rst         (rst),
        .out_start   (out_start),
        .fired       (fired),
        .out_busy    (out_busy),
        .aerout_addr (aerout_addr),
        .aerout_req  (aerout_req),
        .aerout_ack  (aerout_ack)
    );

    goodness_acc u_good (
        .CLK          (CLK),
        .rst          (rst),
        .good_start   (good_start),
        .spike_counts (spike_counts),
        .good_done    (good_done),
        .goodness     (goodness)
    );

endmodule

//--- dv/snn_core_tb.sv
`timescale 1ns/1ps
`include "snn_consts.svh"

module snn_core_tb;

    localparam logic [1:0] K_PROG  = 2'd0;   // write one synapse row
    localparam logic [1:0] K_EVENT = 2'd1;   // AER word, repeated rep times
    localparam int STIM_N     = 32;
    localparam int WAIT_LIMIT = 400;         // cycles per handshake wait
    localparam int MEM_HI = (1 << (`SNN_MEM_WIDTH - 1)) - 1;
    localparam int MEM_LO = -(1 << (`SNN_MEM_WIDTH - 1));

    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  addr;   // row index or AER word
        logic [63:0] row;    // neuron 0 in the low byte
        logic [7:0]  rep;
    } stim_t;

    logic                CLK;
    logic                rst;
    snn_pkg::aer_addr_t  aerin_addr;
    logic                aerin_req;
    logic                aerin_ack;
    snn_pkg::aer_addr_t  aerout_addr;
    logic                aerout_req;
    logic                aerout_ack;
    logic                prog_we;
    snn_pkg::pre_idx_t   prog_addr;
    snn_pkg::syn_row_t   prog_data;
    logic                sample_done;
    snn_pkg::goodness_t  goodness;

    // ----------------------------------------
    // stimulus table, three samples
    // ----------------------------------------
    stim_t stim [STIM_N] = '{
        // sample 0, plain integrate and fire
        '{K_PROG,  8'h00, 64'h1414_1414_1414_1414, 8'd1},
        '{K_PROG,  8'h01, 64'h4601_2100_40E2_0A32, 8'd1},
        '{K_PROG,  8'h02, 64'h0A0A_F6F6_0505_3030, 8'd1},
        '{K_EVENT, 8'h00, 64'h0, 8'd1},
        '{K_EVENT, 8'h31, 64'h0, 8'd1},   // bits 6:4 ignored, pre 1
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        '{K_EVENT, 8'h00, 64'h0, 8'd2},
        '{K_EVENT, 8'h02, 64'h0, 8'd1},
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        '{K_EVENT, 8'h01, 64'h0, 8'd3},
        '{K_EVENT, 8'hC0, 64'h0, 8'd1},   // marker with stray bits
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        // sample 1, saturation both ways, negative membranes
        '{K_PROG,  8'h03, 64'h0000_0000_807F_807F, 8'd1},
        '{K_PROG,  8'h04, 64'h0000_0005_7F80_7F80, 8'd1},
        '{K_EVENT, 8'h03, 64'h0, 8'd20},
        '{K_EVENT, 8'h04, 64'h0, 8'd17},
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        '{K_EVENT, 8'h04, 64'h0, 8'd1},
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        '{K_EVENT, 8'h03, 64'h0, 8'd2},
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        // sample 2, rows 0 and 1 rewritten
        '{K_PROG,  8'h00, 64'h103F_FF7F_0020_C040, 8'd1},
        '{K_PROG,  8'h01, 64'h2121_2121_2121_2121, 8'd1},
        '{K_EVENT, 8'h00, 64'h0, 8'd1},
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        '{K_EVENT, 8'h01, 64'h0, 8'd2},
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        '{K_EVENT, 8'h00, 64'h0, 8'd1},
        '{K_EVENT, 8'h01, 64'h0, 8'd1},
        '{K_EVENT, 8'h80, 64'h0, 8'd1},
        '{K_EVENT, 8'h80, 64'h0, 8'd1}
    };

    // reference model state
    logic [63:0] row_m [`SNN_N_PRE];
    int          mem_m [`SNN_N_POST];
    int          cnt_m [`SNN_N_POST];
    int          step_idx;
    int          good_m;
    int          exp_q [$];              // expected spikes of this step

    snn_pkg::aer_addr_t got_q [$];       // spikes seen on the output link
    bit                 hs_open;         // output handshake in flight
    int                 done_seen;
    snn_pkg::goodness_t done_good;
    int unsigned        rng_state = 12;
    int                 checks;
    int                 errors;
    int                 timeouts;
    bit                 timed_out;

    snn_core UUT (
        .CLK         (CLK),
        .rst         (rst),
        .aerin_addr  (aerin_addr),
        .aerin_req   (aerin_req),
        .aerin_ack   (aerin_ack),
        .aerout_addr (aerout_addr),
        .aerout_req  (aerout_req),
        .aerout_ack  (aerout_ack),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .sample_done (sample_done),
        .goodness    (goodness)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic tick();
        @(posedge CLK);
        #2;   // drive and sample point
    endtask

    function automatic int unsigned lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 16;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int sat_add(input int m, input int w);
        int s;
        s = m + w;
        if (s > MEM_HI) return MEM_HI;
        if (s < MEM_LO) return MEM_LO;
        return s;
    endfunction

    task automatic integrate_row(input snn_pkg::pre_idx_t pre);
        int w;
        for (int n = 0; n < `SNN_N_POST; n++) begin
            w = int'($signed(row_m[pre][n*`SNN_W_WIDTH +: `SNN_W_WIDTH]));
            mem_m[n] = sat_add(mem_m[n], w);
        end
    endtask

    // threshold, reset on fire, ascending order, goodness at sample end
    task automatic fire_step();
        for (int n = 0; n < `SNN_N_POST; n++) begin
            if (mem_m[n] >= `SNN_THRESHOLD) begin
                exp_q.push_back(n);
                mem_m[n] = 0;
                cnt_m[n]++;
            end
        end
        if (step_idx == `SNN_TIME_STEPS - 1) begin
            good_m = 0;
            for (int n = 0; n < `SNN_N_POST; n++) begin
                good_m += cnt_m[n] * cnt_m[n];
                mem_m[n] = 0;
                cnt_m[n] = 0;
            end
            step_idx = 0;
        end else begin
            step_idx++;
        end
    endtask

    task automatic write_row(input snn_pkg::pre_idx_t addr, input logic [63:0] row);
        prog_we   = 1'b1;
        prog_addr = addr;
        prog_data = row;
        row_m[addr] = row;
        tick();
        prog_we = 1'b0;
    endtask

    // poll aerin_ack, catching a sample_done pulse on the way
    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        while (aerin_ack !== level && !timed_out) begin
            tick();
            cycles++;
            if (sample_done === 1'b1) begin
                done_seen++;
                done_good = goodness;
            end
            if (cycles > WAIT_LIMIT && aerin_ack !== level) begin
                $display("ERROR: timeout waiting for aerin_ack to become %0d", level);
                errors++;
                timeouts++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic check_step(input bit last);
        int n;
        n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
        check_value("spike count", 64'(got_q.size()), 64'(exp_q.size()));
        for (int k = 0; k < n; k++) begin
            check_value("aerout_addr", 64'(got_q[k]), 64'(exp_q[k]));
        end
        check_value("aerout handshake open", 64'(hs_open), 64'd0);
        check_value("sample_done", 64'(done_seen), last ? 64'd1 : 64'd0);
        if (last) begin
            check_value("goodness", 64'(done_good), 64'(good_m));
        end
    endtask

    task automatic send_event(input snn_pkg::aer_addr_t addr);
        int  lat;
        bit  marker;
        bit  last;
        marker = addr[`SNN_AER_WIDTH-1];
        last   = marker && (step_idx == `SNN_TIME_STEPS - 1);
        exp_q.delete();
        got_q.delete();
        done_seen = 0;
        if (marker) begin
            fire_step();
        end else begin
            integrate_row(snn_pkg::pre_idx_t'(addr));
        end
        aerin_addr = addr;
        aerin_req  = 1'b1;
        wait_ack(1'b1, lat);
        if (!timed_out) begin
            aerin_req = 1'b0;   // release phase
            if (marker) begin
                check_step(last);
            end else begin
                check_value("aerin_ack latency", 64'(lat), 64'd3);
            end
            wait_ack(1'b0, lat);
        end
    endtask

    // ----------------------------------------
    // output link receiver, random ack delay
    // ----------------------------------------
    initial begin : ack_responder
        int          stage;   // 0 idle, 1 delaying, 2 ack high
        int unsigned delay;
        int          hold;
        stage = 0;
        delay = 0;
        hold  = 0;
        forever begin
            tick();
            case (stage)
                0: begin
                    if (aerout_req === 1'b1) begin
                        got_q.push_back(aerout_addr);
                        hs_open = 1'b1;
                        delay   = lcg_next() % 32'd6;
                        hold    = 0;
                        if (delay == 0) begin
                            aerout_ack = 1'b1;
                            stage = 2;
                        end else begin
                            stage = 1;
                        end
                    end
                end
                1: begin
                    delay--;
                    if (delay == 0) begin
                        aerout_ack = 1'b1;
                        stage = 2;
                    end
                end
                default: begin
                    if (aerout_req === 1'b0) begin
                        aerout_ack = 1'b0;   // spike complete
                        hs_open = 1'b0;
                        stage = 0;
                    end else begin
                        hold++;
                        if (hold == WAIT_LIMIT) begin
                            $display("ERROR: aerout_req stayed high after aerout_ack rose");
                            errors++;
                            timeouts++;
                        end
                    end
                end
            endcase
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : main_seq
        rst        = 1'b1;
        aerin_addr = '0;
        aerin_req  = 1'b0;
        aerout_ack = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        step_idx   = 0;
        good_m     = 0;
        hs_open    = 1'b0;
        for (int n = 0; n < `SNN_N_POST; n++) begin
            mem_m[n] = 0;
            cnt_m[n] = 0;
        end
        repeat (3) tick();
        rst = 1'b0;

        check_value("aerin_ack", 64'(aerin_ack), 64'd0);   // reset state
        check_value("aerout_req", 64'(aerout_req), 64'd0);
        check_value("sample_done", 64'(sample_done), 64'd0);
        check_value("goodness", 64'(goodness), 64'd0);

        for (int i = 0; i < STIM_N && !timed_out; i++) begin
            if (stim[i].kind == K_PROG) begin
                write_row(snn_pkg::pre_idx_t'(stim[i].addr), stim[i].row);
            end else begin
                for (int r = 0; r < int'(stim[i].rep) && !timed_out; r++) begin
                    send_event(stim[i].addr);
                end
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+source
source/snn_pkg.sv
source/tstep_counter.sv
source/synapse_mem.sv
source/neuron_array.sv
source/spike_aer_out.sv
source/goodness_acc.sv
source/snn_controller.sv
source/snn_core.sv
dv/snn_core_tb.sv

//--- Makefile
# Verilator flow for the SNN core testbench

VERILATOR ?= verilator
TOP       := snn_core_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --Mdir $(OBJ_DIR)
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status comes from the grep on the simulator output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
